/* loop_core.f */
source/loop_pkg.sv
source/frame_fifo.sv
source/link_monitor.sv
source/loop_core.sv
tests/frame_fifo_asserts.sv
tests/loop_core_tb.sv

/* Makefile */
# Verilator flow for the loopback core testbench

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module loop_core_tb \
		-f loop_core.f -Mdir obj_dir

run: compile
	./obj_dir/Vloop_core_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "Run failed, see sim.log"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then echo "Run ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

/* tests/loop_core_tb.sv */
// Testbench for the two-channel loopback core, seeded random frames against a beat-level model
`timescale 1ns/1ps

module loop_core_tb;

    localparam int CH = loop_pkg::CH_COUNT;
    localparam int CLK_PERIOD = 8;
    localparam int MAX_LEN = 30;
    // Frames per channel over all phases, each at most MAX_LEN beats and a gap of 3
    localparam int TOTAL_FRAMES = 80;
    localparam int WATCHDOG_NS = TOTAL_FRAMES * (MAX_LEN + 3) * 4 * CLK_PERIOD + 20000;
    localparam int BUF_MASK = 127;

    logic                        clk_125mhz;
    logic                        rst_n;
    logic [loop_pkg::DATA_W-1:0] rx_data            [CH];
    logic [loop_pkg::KEEP_W-1:0] rx_keep            [CH];
    logic                        rx_last            [CH];
    logic                        rx_user            [CH];
    logic                        rx_valid           [CH];
    logic                        rx_block_lock      [CH];
    logic [loop_pkg::DATA_W-1:0] tx_data            [CH];
    logic [loop_pkg::KEEP_W-1:0] tx_keep            [CH];
    logic                        tx_last            [CH];
    logic                        tx_valid           [CH];
    logic                        tx_ready           [CH];
    logic                        frame_status_valid [CH];
    loop_pkg::frame_status_t     frame_status       [CH];
    logic [1:0]                  sfp_led            [CH];

    // Reference model, committed beats per channel in a circular buffer
    logic [loop_pkg::DATA_W-1:0] exp_data  [CH][BUF_MASK+1];
    logic [loop_pkg::KEEP_W-1:0] exp_keep  [CH][BUF_MASK+1];
    logic                        exp_last  [CH][BUF_MASK+1];
    int                          exp_head  [CH];
    int                          exp_tail  [CH];
    logic [loop_pkg::DATA_W-1:0] cur_data  [CH][MAX_LEN];
    logic [loop_pkg::KEEP_W-1:0] cur_keep  [CH][MAX_LEN];
    int                          cur_cnt   [CH];
    logic                        in_drop   [CH];
    loop_pkg::frame_status_t     drop_stat [CH];
    loop_pkg::frame_status_t     exp_stat  [CH];
    logic                        stat_due  [CH];
    int                          lock_run  [CH];
    int                          act_left  [CH];
    int                          seen_stat [4];
    int                          link_seen;
    int                          act_seen;
    int                          checks;
    int                          errors;

    // Stimulus state
    int                          seed;
    int                          beat_idx   [CH];
    int                          frame_len  [CH];
    logic                        frame_err  [CH];
    int                          gap_left   [CH];
    int                          sent       [CH];
    int                          target     [CH];
    int                          lock_left  [CH];
    logic                        lock_level [CH];
    int                          fixed_len;

    loop_core i_dut (.*);

    initial clk_125mhz = 1'b0;
    always #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;

    function automatic int urand(input int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic compare_value(input string name, input int c, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s on channel %0d is %0h, expected %0h",
                     $time, name, c, got, exp);
        end
    endtask

    // Free space counts committed beats not yet taken by the sink
    task automatic model_rx(input int c);
        int stored;
        stored = exp_tail[c] - exp_head[c];
        if (!in_drop[c]) begin
            if (cur_cnt[c] == loop_pkg::MAX_FRAME_BEATS) begin
                in_drop[c] = 1'b1;
                drop_stat[c] = loop_pkg::FRAME_OVERSIZE;
            end else if (stored + cur_cnt[c] >= loop_pkg::FIFO_DEPTH) begin
                in_drop[c] = 1'b1;
                drop_stat[c] = loop_pkg::FRAME_OVERFLOW;
            end else begin
                cur_data[c][cur_cnt[c]] = rx_data[c];
                cur_keep[c][cur_cnt[c]] = rx_keep[c];
                cur_cnt[c]++;
            end
        end
        if (rx_last[c]) begin
            if (in_drop[c]) begin
                exp_stat[c] = drop_stat[c];
            end else if (rx_user[c]) begin
                exp_stat[c] = loop_pkg::FRAME_BAD;
            end else begin
                for (int i = 0; i < cur_cnt[c]; i++) begin
                    exp_data[c][exp_tail[c] & BUF_MASK] = cur_data[c][i];
                    exp_keep[c][exp_tail[c] & BUF_MASK] = cur_keep[c][i];
                    exp_last[c][exp_tail[c] & BUF_MASK] = (i == cur_cnt[c] - 1);
                    exp_tail[c]++;
                end
                exp_stat[c] = loop_pkg::FRAME_GOOD;
            end
            stat_due[c] = 1'b1;
            cur_cnt[c] = 0;
            in_drop[c] = 1'b0;
        end
    endtask

    task automatic model_tx(input int c);
        int idx;
        checks++;
        assert (exp_head[c] != exp_tail[c]) else begin
            errors++;
            $display("Channel %0d sent a beat at %0t with no frame waiting", c, $time);
        end
        if (exp_head[c] != exp_tail[c]) begin
            idx = exp_head[c] & BUF_MASK;
            compare_value("tx_data", c, tx_data[c], exp_data[c][idx]);
            compare_value("tx_keep", c, 64'(tx_keep[c]), 64'(exp_keep[c][idx]));
            compare_value("tx_last", c, 64'(tx_last[c]), 64'(exp_last[c][idx]));
            exp_head[c]++;
        end
    endtask

    // Monitor, all values sampled as they were before the edge
    always @(posedge clk_125mhz) begin
        for (int c = 0; c < CH; c++) begin
            if (!rst_n) begin
                exp_head[c] = 0;
                exp_tail[c] = 0;
                cur_cnt[c] = 0;
                in_drop[c] = 1'b0;
                stat_due[c] = 1'b0;
                lock_run[c] = 0;
                act_left[c] = 0;
            end else begin
                compare_value("frame_status_valid", c, 64'(frame_status_valid[c]),
                              64'(stat_due[c]));
                if (frame_status_valid[c] && stat_due[c]) begin
                    compare_value("frame_status", c, 64'(frame_status[c]), 64'(exp_stat[c]));
                    seen_stat[int'(exp_stat[c])]++;
                end
                compare_value("sfp_led bit 0", c, 64'(sfp_led[c][0]),
                              64'(lock_run[c] >= loop_pkg::LINK_UP_CYCLES));
                compare_value("sfp_led bit 1", c, 64'(sfp_led[c][1]), 64'(act_left[c] != 0));
                if (sfp_led[c][0]) link_seen++;
                if (sfp_led[c][1]) act_seen++;

                if (stat_due[c] && exp_stat[c] == loop_pkg::FRAME_GOOD) begin
                    act_left[c] = loop_pkg::ACT_HOLD_CYCLES;
                end else if (act_left[c] != 0) begin
                    act_left[c]--;
                end
                if (!rx_block_lock[c]) begin
                    lock_run[c] = 0;
                end else if (lock_run[c] < loop_pkg::LINK_UP_CYCLES) begin
                    lock_run[c]++;
                end
                stat_due[c] = 1'b0;
                if (rx_valid[c]) model_rx(c);
                if (tx_valid[c] && tx_ready[c]) model_tx(c);
            end
        end
    end

    task automatic drive_cycle(input int ready_pct);
        logic last;
        @(posedge clk_125mhz);
        for (int c = 0; c < CH; c++) begin
            // Lock runs of random length, only some reach the link-up window
            if (lock_left[c] == 0) begin
                lock_level[c] = !lock_level[c];
                lock_left[c] = lock_level[c] ? 1 + urand(30) : 1 + urand(6);
            end
            lock_left[c]--;
            rx_block_lock[c] <= lock_level[c];
            tx_ready[c] <= (urand(100) < ready_pct);

            if (beat_idx[c] == 0 && (gap_left[c] != 0 || sent[c] >= target[c])) begin
                if (gap_left[c] != 0) gap_left[c]--;
                rx_valid[c] <= 1'b0;
                rx_last[c] <= 1'b0;
            end else begin
                if (beat_idx[c] == 0) begin
                    frame_len[c] = (fixed_len != 0) ? fixed_len : 1 + urand(MAX_LEN);
                    frame_err[c] = (urand(8) == 0);
                end
                last = (beat_idx[c] == frame_len[c] - 1);
                rx_valid[c] <= 1'b1;
                rx_data[c] <= {$random(seed), $random(seed)};
                rx_keep[c] <= last ? 8'(urand(256)) : 8'hff;
                rx_last[c] <= last;
                // User bit only counts on the last beat
                rx_user[c] <= last ? frame_err[c] : 1'(urand(2));
                if (last) begin
                    beat_idx[c] = 0;
                    sent[c]++;
                    gap_left[c] = urand(4);
                end else begin
                    beat_idx[c]++;
                end
            end
        end
    endtask

    task automatic send_frames(input int n, input int len, input int ready_pct);
        fixed_len = len;
        for (int c = 0; c < CH; c++) target[c] = sent[c] + n;
        while (sent[0] < target[0] || sent[1] < target[1]) drive_cycle(ready_pct);
    endtask

    task automatic drain_all();
        repeat (4) drive_cycle(100);
        while (exp_head[0] != exp_tail[0] || exp_head[1] != exp_tail[1]) drive_cycle(100);
        repeat (4) drive_cycle(100);
    endtask

    initial begin
        seed = 32'h5e0b_d5e0;
        checks = 0;
        errors = 0;
        link_seen = 0;
        act_seen = 0;
        fixed_len = 0;
        rst_n = 1'b0;
        for (int c = 0; c < CH; c++) begin
            rx_data[c] = '0;
            rx_keep[c] = '0;
            rx_last[c] = 1'b0;
            rx_user[c] = 1'b0;
            rx_valid[c] = 1'b0;
            rx_block_lock[c] = 1'b0;
            tx_ready[c] = 1'b0;
            beat_idx[c] = 0;
            gap_left[c] = 0;
            sent[c] = 0;
            target[c] = 0;
            lock_left[c] = 0;
            lock_level[c] = 1'b0;
        end
        for (int k = 0; k < 4; k++) seen_stat[k] = 0;
        repeat (3) @(posedge clk_125mhz);
        rst_n <= 1'b1;

        // Mixed traffic with light back-pressure
        send_frames(40, 0, 75);
        // Longest legal frame, then oversize
        send_frames(3, loop_pkg::MAX_FRAME_BEATS, 60);
        send_frames(3, loop_pkg::MAX_FRAME_BEATS + 1, 60);
        send_frames(2, MAX_LEN, 60);
        drain_all();
        // Sink stalled, later frames run out of room
        send_frames(12, 0, 0);
        drain_all();
        send_frames(20, 0, 50);
        drain_all();

        for (int k = 0; k < 4; k++) begin
            checks++;
            assert (seen_stat[k] != 0) else begin
                errors++;
                $display("No frame ended with status code %0d during the run", k);
            end
        end
        checks++;
        assert (link_seen != 0 && act_seen != 0) else begin
            errors++;
            $display("Link or activity LED never lit during the run");
        end

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* tests/frame_fifo_asserts.sv */
// Concurrent checks on the frame FIFO transmit handshake, status pulses and writer FSM
`timescale 1ns/1ps

module frame_fifo_asserts (
    input logic                        clk_125mhz,
    input logic                        rst_n,
    input logic                        rx_valid,
    input logic                        rx_last,
    input logic [loop_pkg::DATA_W-1:0] tx_data,
    input logic [loop_pkg::KEEP_W-1:0] tx_keep,
    input logic                        tx_last,
    input logic                        tx_valid,
    input logic                        tx_ready,
    input logic                        frame_status_valid,
    input loop_pkg::wr_state_t         wr_state
);

    // Stalled beat stays put until the sink takes it
    tx_hold: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_keep)
            && $stable(tx_last))
        else $error("tx beat changed while the sink stalled");

    reset_quiet: assert property (@(posedge clk_125mhz)
        !rst_n |=> !tx_valid && !frame_status_valid)
        else $error("tx_valid or frame_status_valid high right after reset");

    // A status pulse always finds the writer back in idle
    status_at_idle: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        frame_status_valid |-> wr_state == loop_pkg::WR_IDLE)
        else $error("status pulse while the writer was still inside a frame");

    // Every return to idle closes a frame and reports it
    idle_reports: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        wr_state == loop_pkg::WR_IDLE && $past(wr_state) != loop_pkg::WR_IDLE
            |-> frame_status_valid)
        else $error("writer went back to idle without a status pulse");

    drop_until_last: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        wr_state == loop_pkg::WR_DROP && !(rx_valid && rx_last)
            |=> wr_state == loop_pkg::WR_DROP)
        else $error("writer left the drop state before the last beat");

endmodule

bind frame_fifo frame_fifo_asserts i_asserts (
    .clk_125mhz         (clk_125mhz),
    .rst_n              (rst_n),
    .rx_valid           (rx_valid),
    .rx_last            (rx_last),
    .tx_data            (tx_data),
    .tx_keep            (tx_keep),
    .tx_last            (tx_last),
    .tx_valid           (tx_valid),
    .tx_ready           (tx_ready),
    .frame_status_valid (frame_status_valid),
    .wr_state           (wr_state)
);

/* source/loop_core.sv */
// Two-channel frame loopback top, each SFP receive stream returns on its own transmit stream
`timescale 1ns/1ps

module loop_core (
    // 125 MHz system clock
    input  logic                        clk_125mhz,
    input  logic                        rst_n,

    // Receive streams from the MACs
    input  logic [loop_pkg::DATA_W-1:0] rx_data            [loop_pkg::CH_COUNT],
    input  logic [loop_pkg::KEEP_W-1:0] rx_keep            [loop_pkg::CH_COUNT],
    input  logic                        rx_last            [loop_pkg::CH_COUNT],
    input  logic                        rx_user            [loop_pkg::CH_COUNT],
    input  logic                        rx_valid           [loop_pkg::CH_COUNT],

    // PCS block lock per port
    input  logic                        rx_block_lock      [loop_pkg::CH_COUNT],

    // Transmit streams back to the MACs
    output logic [loop_pkg::DATA_W-1:0] tx_data            [loop_pkg::CH_COUNT],
    output logic [loop_pkg::KEEP_W-1:0] tx_keep            [loop_pkg::CH_COUNT],
    output logic                        tx_last            [loop_pkg::CH_COUNT],
    output logic                        tx_valid           [loop_pkg::CH_COUNT],
    input  logic                        tx_ready           [loop_pkg::CH_COUNT],

    // Frame results
    output logic                        frame_status_valid [loop_pkg::CH_COUNT],
    output loop_pkg::frame_status_t     frame_status       [loop_pkg::CH_COUNT],

    // Front panel LEDs
    output logic [1:0]                  sfp_led            [loop_pkg::CH_COUNT]
);

    for (genvar n = 0; n < loop_pkg::CH_COUNT; n++) begin : g_ch

        // Loopback path, frames received on a port go back out the same port
        frame_fifo i_fifo (
            .clk_125mhz         (clk_125mhz),
            .rst_n              (rst_n),
            .rx_data            (rx_data[n]),
            .rx_keep            (rx_keep[n]),
            .rx_last            (rx_last[n]),
            .rx_user            (rx_user[n]),
            .rx_valid           (rx_valid[n]),
            .tx_data            (tx_data[n]),
            .tx_keep            (tx_keep[n]),
            .tx_last            (tx_last[n]),
            .tx_valid           (tx_valid[n]),
            .tx_ready           (tx_ready[n]),
            .frame_status_valid (frame_status_valid[n]),
            .frame_status       (frame_status[n])
        );

        // Status LEDs fed by the lock input and the FIFO results
        link_monitor i_mon (
            .clk_125mhz         (clk_125mhz),
            .rst_n              (rst_n),
            .rx_block_lock      (rx_block_lock[n]),
            .frame_status_valid (frame_status_valid[n]),
            .frame_status       (frame_status[n]),
            .led                (sfp_led[n])
        );

    end

endmodule

/* source/link_monitor.sv */
// Per-channel link monitor, debounces block lock into a link LED and stretches good frames
`timescale 1ns/1ps

module link_monitor (
    input  logic                    clk_125mhz,
    input  logic                    rst_n,

    // PCS block lock
    input  logic                    rx_block_lock,

    // Frame results from the FIFO
    input  logic                    frame_status_valid,
    input  loop_pkg::frame_status_t frame_status,

    // Bit 0 link, bit 1 activity
    output logic [1:0]              led
);

    loop_pkg::lock_cnt_t lock_cnt;
    loop_pkg::act_cnt_t  act_cnt;
    logic                good_frame;

    assign good_frame = frame_status_valid && (frame_status == loop_pkg::FRAME_GOOD);

    // Consecutive lock cycles, saturating at the threshold
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            lock_cnt <= '0;
        end else if (!rx_block_lock) begin
            lock_cnt <= '0;
        end else if (lock_cnt != loop_pkg::lock_cnt_t'(loop_pkg::LINK_UP_CYCLES)) begin
            lock_cnt <= lock_cnt + 1'b1;
        end
    end

    // Activity hold, restarted by every good frame
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            act_cnt <= '0;
        end else if (good_frame) begin
            act_cnt <= loop_pkg::act_cnt_t'(loop_pkg::ACT_HOLD_CYCLES);
        end else if (act_cnt != '0) begin
            act_cnt <= act_cnt - 1'b1;
        end
    end

    // Link stays down until lock has held for the full window
    assign led[0] = (lock_cnt == loop_pkg::lock_cnt_t'(loop_pkg::LINK_UP_CYCLES));
    assign led[1] = (act_cnt != '0);

endmodule

/* source/frame_fifo.sv */
// Store-and-forward frame FIFO, commits whole frames and drops bad or oversize or overflowing ones
`timescale 1ns/1ps

module frame_fifo (
    input  logic                        clk_125mhz,
    input  logic                        rst_n,

    // Receive stream, no back-pressure
    input  logic [loop_pkg::DATA_W-1:0] rx_data,
    input  logic [loop_pkg::KEEP_W-1:0] rx_keep,
    input  logic                        rx_last,
    input  logic                        rx_user,
    input  logic                        rx_valid,

    // Transmit stream
    output logic [loop_pkg::DATA_W-1:0] tx_data,
    output logic [loop_pkg::KEEP_W-1:0] tx_keep,
    output logic                        tx_last,
    output logic                        tx_valid,
    input  logic                        tx_ready,

    // Per-frame result
    output logic                        frame_status_valid,
    output loop_pkg::frame_status_t     frame_status
);

    // Beat storage, keep and last travel with the data
    logic [loop_pkg::DATA_W-1:0] mem_data [loop_pkg::FIFO_DEPTH];
    logic [loop_pkg::KEEP_W-1:0] mem_keep [loop_pkg::FIFO_DEPTH];
    logic                        mem_last [loop_pkg::FIFO_DEPTH];

    // Provisional write pointer, last commit point and read fetch pointer
    loop_pkg::ptr_t wr_ptr;
    loop_pkg::ptr_t wr_commit;
    loop_pkg::ptr_t rd_ptr;

    loop_pkg::wr_state_t     wr_state;
    loop_pkg::len_t          beat_cnt;
    loop_pkg::frame_status_t drop_reason;

    // Writer decode
    loop_pkg::ptr_t rd_hold_ptr;
    loop_pkg::ptr_t wr_used;
    logic           frame_beat;
    logic           over_size;
    logic           no_room;
    logic           drop_now;
    logic           wr_en;

    // Reader decode
    logic           rd_avail;
    logic           rd_load;

    // A beat parked in the output register still holds its slot until handed off
    assign rd_hold_ptr = rd_ptr - tx_valid;
    assign wr_used = wr_ptr - rd_hold_ptr;

    assign frame_beat = rx_valid && (wr_state != loop_pkg::WR_DROP);

    // This beat would be one past the longest legal frame
    assign over_size = (wr_state == loop_pkg::WR_FRAME) &&
                       (beat_cnt == loop_pkg::len_t'(loop_pkg::MAX_FRAME_BEATS));

    // Every slot is taken by committed or provisional beats
    assign no_room = (wr_used == loop_pkg::ptr_t'(loop_pkg::FIFO_DEPTH));

    assign drop_now = frame_beat && (over_size || no_room);
    assign wr_en = frame_beat && !drop_now;

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem_data[wr_ptr[loop_pkg::ADDR_W-1:0]] <= rx_data;
            mem_keep[wr_ptr[loop_pkg::ADDR_W-1:0]] <= rx_keep;
            mem_last[wr_ptr[loop_pkg::ADDR_W-1:0]] <= rx_last;
        end
    end

    // Frame writer FSM
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            wr_state <= loop_pkg::WR_IDLE;
            wr_ptr <= '0;
            wr_commit <= '0;
            beat_cnt <= '0;
            drop_reason <= loop_pkg::FRAME_OVERFLOW;
            frame_status_valid <= 1'b0;
            frame_status <= loop_pkg::FRAME_GOOD;
        end else begin
            // One status pulse per frame, always the cycle after its last beat
            frame_status_valid <= rx_valid && rx_last;

            if (rx_valid) begin
                case (wr_state)
                    loop_pkg::WR_IDLE, loop_pkg::WR_FRAME: begin
                        if (drop_now) begin
                            // Discard everything written for this frame
                            wr_ptr <= wr_commit;
                            beat_cnt <= '0;
                            if (over_size) begin
                                drop_reason <= loop_pkg::FRAME_OVERSIZE;
                                frame_status <= loop_pkg::FRAME_OVERSIZE;
                            end else begin
                                drop_reason <= loop_pkg::FRAME_OVERFLOW;
                                frame_status <= loop_pkg::FRAME_OVERFLOW;
                            end
                            if (rx_last) begin
                                wr_state <= loop_pkg::WR_IDLE;
                            end else begin
                                wr_state <= loop_pkg::WR_DROP;
                            end
                        end else if (rx_last) begin
                            beat_cnt <= '0;
                            wr_state <= loop_pkg::WR_IDLE;
                            if (rx_user) begin
                                // Errored frame, rewind to the last commit
                                wr_ptr <= wr_commit;
                                frame_status <= loop_pkg::FRAME_BAD;
                            end else begin
                                wr_ptr <= wr_ptr + 1'b1;
                                wr_commit <= wr_ptr + 1'b1;
                                frame_status <= loop_pkg::FRAME_GOOD;
                            end
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                            beat_cnt <= beat_cnt + 1'b1;
                            wr_state <= loop_pkg::WR_FRAME;
                        end
                    end

                    loop_pkg::WR_DROP: begin
                        // Swallow the tail, report why it went
                        if (rx_last) begin
                            wr_state <= loop_pkg::WR_IDLE;
                            frame_status <= drop_reason;
                        end
                    end

                    default: begin
                        wr_state <= loop_pkg::WR_IDLE;
                    end
                endcase
            end
        end
    end

    // Reader pulls only from the committed region
    assign rd_avail = (rd_ptr != wr_commit);
    assign rd_load = rd_avail && (!tx_valid || tx_ready);

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            tx_valid <= 1'b0;
        end else if (rd_load) begin
            rd_ptr <= rd_ptr + 1'b1;
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    // Output register, holds while the sink stalls
    always_ff @(posedge clk_125mhz) begin
        if (rd_load) begin
            tx_data <= mem_data[rd_ptr[loop_pkg::ADDR_W-1:0]];
            tx_keep <= mem_keep[rd_ptr[loop_pkg::ADDR_W-1:0]];
            tx_last <= mem_last[rd_ptr[loop_pkg::ADDR_W-1:0]];
        end
    end

endmodule

/* source/loop_pkg.sv */
// Loop core package with sizing constants, counter types and shared enums
package loop_pkg;

    // Channel and beat sizing
    localparam int CH_COUNT = 2;
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // Frame FIFO sizing, pointers carry one wrap bit
    localparam int FIFO_DEPTH = 64;
    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W = ADDR_W + 1;
    localparam int MAX_FRAME_BEATS = 24;
    localparam int LEN_W = $clog2(MAX_FRAME_BEATS + 1);

    // Link monitor timing in clock cycles
    localparam int LINK_UP_CYCLES = 16;
    localparam int ACT_HOLD_CYCLES = 32;
    localparam int LOCK_W = $clog2(LINK_UP_CYCLES + 1);
    localparam int ACT_W = $clog2(ACT_HOLD_CYCLES + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [LOCK_W-1:0] lock_cnt_t;
    typedef logic [ACT_W-1:0] act_cnt_t;

    // Frame writer FSM
    typedef enum logic [1:0] {WR_IDLE, WR_FRAME, WR_DROP} wr_state_t;

    // Result of one received frame
    typedef enum logic [1:0] {
        FRAME_GOOD,
        FRAME_BAD,
        FRAME_OVERSIZE,
        FRAME_OVERFLOW
    } frame_status_t;

endpackage
